// File: Bender.yml
package:
  name: mm_accel

export_include_dirs:
  - common

sources:
  - common/mm_fixed_pkg.sv
  - common/mm_stream_pkg.sv
  - common/mm_beat_if.sv
  - common/mm_result_if.sv
  - hw/mm_tile_sequencer.sv
  - core/mm_mac_lane.sv
  - core/mm_core.sv
  - buffer/mm_result_buffer.sv
  - hw/mm_accel_top.sv
  - target: test
    files:
      - verification/mm_accel_assertions.sv
      - verification/mm_accel_tb.sv

// File: buffer/mm_result_buffer.sv
/*
 * Captures the rows of all cores at once and sends them in core order.
 * Output credits are counted up to 255, more are lost.
 * A new capture waits until the previous set has left completely.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_result_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       out_credit,
    mm_result_if.buffer                res,
    output logic                       out_valid,
    output mm_stream_pkg::result_row_t out_data,
    output logic                       out_last,
    output logic                       busy
);

    import mm_stream_pkg::*;

    localparam int NUM_CORES = `MM_NUM_CORES;
    localparam int IDX_W     = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam int CREDIT_W  = 8;

    result_set_t         set_q;
    logic                full_q;
    logic [IDX_W-1:0]    row_idx;
    logic [CREDIT_W-1:0] credits;
    logic                take;
    logic                send;
    logic                last_row;

    assign take     = (&res.row_valid) && !full_q;
    assign send     = full_q && (credits != '0);
    assign last_row = (row_idx == IDX_W'(NUM_CORES - 1));

    assign res.take = take;
    // Any held row blocks the next tile start
    assign busy     = |res.row_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q    <= 1'b0;
            row_idx   <= '0;
            credits   <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            credits   <= credits + CREDIT_W'(out_credit) - CREDIT_W'(send);
            out_valid <= send;
            out_last  <= send && last_row;

            if (take) begin
                full_q <= 1'b1;
            end else if (send && last_row) begin
                full_q <= 1'b0;
            end

            if (send) begin
                row_idx <= last_row ? '0 : row_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            set_q <= res.rows;
        end
        if (send) begin
            out_data <= set_q[row_idx];
        end
    end

endmodule

// File: common/mm_beat_if.sv
/*
 * Beat bus from the tile sequencer to all cores.
 * No ready, every core consumes each cycle with valid high.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

interface mm_beat_if;

    import mm_stream_pkg::*;

    logic   valid;
    // Tile boundaries, qualified by valid
    logic   first;
    logic   last;
    a_col_t a;
    b_row_t b;

    modport sequencer (
        output valid,
        output first,
        output last,
        output a,
        output b
    );

    modport core (
        input valid,
        input first,
        input last,
        input a,
        input b
    );

endinterface

// File: common/mm_defines.svh
/*
 * Global sizing for the matrix-multiply accelerator.
 * MM_NUM_CORES may be 1 to 8. The accumulator is sized so that a full
 * tile of MM_INNER_DIM products can never overflow.
 */
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// Fixed-point sample format
`define MM_WIDTH      16
`define MM_FRAC_WIDTH 8

// Array shape
`define MM_CHUNK_SIZE 4
`define MM_NUM_CORES  2
`define MM_INNER_DIM  16

// Input beat FIFO depth, equal to the credits granted after reset
`define MM_IN_CREDITS 4

`define MM_ACC_WIDTH  (2 * `MM_WIDTH + $clog2(`MM_INNER_DIM))

`endif

// File: common/mm_fixed_pkg.sv
/*
 * Signed fixed-point types with MM_FRAC_WIDTH fraction bits.
 * to_sample rounds toward minus infinity and saturates, it never wraps.
 */
`include "mm_defines.svh"

package mm_fixed_pkg;

    typedef logic signed [`MM_WIDTH-1:0]     sample_t;
    typedef logic signed [2*`MM_WIDTH-1:0]   product_t;
    typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

    // Largest and smallest sample value seen at accumulator width
    localparam acc_t SAT_MAX = {{(`MM_ACC_WIDTH-`MM_WIDTH+1){1'b0}}, {(`MM_WIDTH-1){1'b1}}};
    localparam acc_t SAT_MIN = ~SAT_MAX;

    function automatic sample_t to_sample(input acc_t acc);
        acc_t    shifted;
        sample_t res;
        // Arithmetic shift drops the fraction, rounding down
        shifted = acc >>> `MM_FRAC_WIDTH;
        if (shifted > SAT_MAX) begin
            res = SAT_MAX[`MM_WIDTH-1:0];
        end else if (shifted < SAT_MIN) begin
            res = SAT_MIN[`MM_WIDTH-1:0];
        end else begin
            res = shifted[`MM_WIDTH-1:0];
        end
        return res;
    endfunction

endpackage

// File: common/mm_result_if.sv
/*
 * Finished rows from the cores to the result buffer.
 * Each core drives only its own bit and row, take is a one-cycle pulse.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

interface mm_result_if;

    import mm_stream_pkg::*;

    // Nets, since every core drives its own slice
    wire [`MM_NUM_CORES-1:0] row_valid;
    wire result_set_t        rows;

    // Buffer has captured all rows
    logic take;

    modport core (
        output row_valid,
        output rows,
        input  take
    );

    modport buffer (
        input  row_valid,
        input  rows,
        output take
    );

endinterface

// File: common/mm_stream_pkg.sv
/*
 * Payload types moved between sequencer, cores and result buffer.
 * All arrays are packed, element 0 sits in the low bits.
 */
`include "mm_defines.svh"

package mm_stream_pkg;

    import mm_fixed_pkg::*;

    // One row of B, shared by every core
    typedef sample_t [`MM_CHUNK_SIZE-1:0] b_row_t;

    // One A element per core
    typedef sample_t [`MM_NUM_CORES-1:0] a_col_t;

    typedef struct packed {
        a_col_t a;
        b_row_t b;
    } beat_t;

    // Converted output of one core
    typedef sample_t [`MM_CHUNK_SIZE-1:0] result_row_t;

    // Rows of all cores, index equals core number
    typedef result_row_t [`MM_NUM_CORES-1:0] result_set_t;

endpackage

// File: core/mm_core.sv
/*
 * One A-row worth of MAC lanes.
 * The finished row stays valid until the buffer takes it. The sequencer
 * keeps the next tile's last beat from arriving before that.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_core #(
    parameter int CORE_INDEX = 0
) (
    input  logic     clk,
    input  logic     rst_n,
    mm_beat_if.core  beat,
    mm_result_if.core res
);

    import mm_stream_pkg::*;

    result_row_t               lane_result;
    logic [`MM_CHUNK_SIZE-1:0] lane_valid;
    logic                      row_done;
    logic                      held_q;

    if (CORE_INDEX < 0 || CORE_INDEX >= `MM_NUM_CORES) begin : g_bad_index
        $error("mm_core: CORE_INDEX %0d out of range", CORE_INDEX);
    end

    // Same A element feeds every lane, B is split across them
    for (genvar j = 0; j < `MM_CHUNK_SIZE; j++) begin : g_lane
        mm_mac_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .valid        (beat.valid),
            .first        (beat.first),
            .last         (beat.last),
            .a            (beat.a[CORE_INDEX]),
            .b            (beat.b[j]),
            .result       (lane_result[j]),
            .result_valid (lane_valid[j])
        );
    end

    assign row_done = &lane_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else if (res.take) begin
            held_q <= 1'b0;
        end else if (row_done) begin
            held_q <= 1'b1;
        end
    end

    // Valid from the completion pulse onward
    assign res.row_valid[CORE_INDEX] = held_q | row_done;
    assign res.rows[CORE_INDEX]      = lane_result;

endmodule

// File: core/mm_mac_lane.sv
/*
 * Pipelined multiply-accumulate lane.
 * Multiply, accumulate and convert each take one cycle. result holds
 * its value until the next tile completes.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_mac_lane (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  logic                  first,
    input  logic                  last,
    input  mm_fixed_pkg::sample_t a,
    input  mm_fixed_pkg::sample_t b,
    output mm_fixed_pkg::sample_t result,
    output logic                  result_valid
);

    import mm_fixed_pkg::*;

    logic     mul_valid;
    logic     mul_first;
    logic     mul_last;
    logic     acc_done;
    product_t product_q;
    acc_t     acc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_valid    <= 1'b0;
            mul_first    <= 1'b0;
            mul_last     <= 1'b0;
            acc_done     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            mul_valid    <= valid;
            mul_first    <= valid & first;
            mul_last     <= valid & last;
            acc_done     <= mul_valid & mul_last;
            result_valid <= acc_done;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            product_q <= a * b;
        end
        // Full precision sum, restarted by the first beat
        if (mul_valid) begin
            acc_q <= mul_first ? acc_t'(product_q) : acc_q + acc_t'(product_q);
        end
        if (acc_done) begin
            result <= to_sample(acc_q);
        end
    end

endmodule

// File: hw/mm_accel_top.sv
/*
 * Matrix-multiply accelerator top level.
 * Credit flow control on both sides, the DUT grants MM_IN_CREDITS input
 * credits after reset and waits for out_credit before sending rows.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_accel_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  mm_stream_pkg::a_col_t      in_a,
    input  mm_stream_pkg::b_row_t      in_b,
    output logic                       in_credit,
    output logic                       out_valid,
    output mm_stream_pkg::result_row_t out_data,
    output logic                       out_last,
    input  logic                       out_credit
);

    import mm_stream_pkg::*;

    beat_t in_beat;
    logic  cores_busy;

    mm_beat_if   beat_bus ();
    mm_result_if result_bus ();

    assign in_beat = '{a: in_a, b: in_b};

    mm_tile_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .cores_busy (cores_busy),
        .in_credit  (in_credit),
        .beat       (beat_bus.sequencer)
    );

    // One core per A row of the tile
    for (genvar i = 0; i < `MM_NUM_CORES; i++) begin : g_core
        mm_core #(
            .CORE_INDEX (i)
        ) u_core (
            .clk   (clk),
            .rst_n (rst_n),
            .beat  (beat_bus.core),
            .res   (result_bus.core)
        );
    end

    mm_result_buffer u_result_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_credit (out_credit),
        .res        (result_bus.buffer),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .busy       (cores_busy)
    );

endmodule

// File: hw/mm_tile_sequencer.sv
/*
 * Input credit issue, beat FIFO and tile gating.
 * The sender must hold a credit for every in_valid, an overrun is not
 * detected here. First beats wait until the previous tile has been taken.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_tile_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  mm_stream_pkg::beat_t in_beat,
    input  logic                 cores_busy,
    output logic                 in_credit,
    mm_beat_if.sequencer         beat
);

    import mm_stream_pkg::*;

    localparam int DEPTH = `MM_IN_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int IDX_W = (`MM_INNER_DIM > 1) ? $clog2(`MM_INNER_DIM) : 1;

    beat_t            fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic [CNT_W-1:0] credits_owed;
    logic [IDX_W-1:0] beat_idx;
    logic             tile_pending;
    logic             head_first;
    logic             head_last;
    logic             push;
    logic             pop;
    logic             grant;

    assign push       = in_valid;
    assign head_first = (beat_idx == '0);
    assign head_last  = (beat_idx == IDX_W'(`MM_INNER_DIM - 1));
    // A finished tile needs three cycles to show up as busy
    assign pop   = (fifo_count != '0) && !(head_first && (cores_busy || tile_pending));
    assign grant = (credits_owed != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_count   <= '0;
            credits_owed <= CNT_W'(DEPTH);
            in_credit    <= 1'b0;
            beat_idx     <= '0;
            tile_pending <= 1'b0;
            beat.valid   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                beat_idx <= head_last ? '0 : beat_idx + 1'b1;
            end
            fifo_count <= fifo_count + CNT_W'(push) - CNT_W'(pop);

            // Initial credits first, then one per beat released
            in_credit    <= grant;
            credits_owed <= credits_owed + CNT_W'(pop) - CNT_W'(grant);

            if (pop && head_last) begin
                tile_pending <= 1'b1;
            end else if (cores_busy) begin
                tile_pending <= 1'b0;
            end

            beat.valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            beat.first <= head_first;
            beat.last  <= head_last;
            beat.a     <= fifo_mem[rd_ptr].a;
            beat.b     <= fifo_mem[rd_ptr].b;
        end
    end

endmodule

// File: mm_accel.f
+incdir+common
common/mm_fixed_pkg.sv
common/mm_stream_pkg.sv
common/mm_beat_if.sv
common/mm_result_if.sv
hw/mm_tile_sequencer.sv
core/mm_mac_lane.sv
core/mm_core.sv
buffer/mm_result_buffer.sv
hw/mm_accel_top.sv
verification/mm_accel_assertions.sv
verification/mm_accel_tb.sv

// File: verification/mm_accel_assertions.sv
/*
 * Credit and reset checks for mm_accel_top, attached with bind.
 * Balances count pulses seen at the top-level ports only.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_accel_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_last,
    input logic out_credit
);

    localparam int IN_CREDITS = `MM_IN_CREDITS;

    int   in_balance;
    int   out_balance;
    int   reset_credits;
    logic beat_seen;
    logic clocked = 1'b0;
    int   fail_count = 0;

    always_ff @(posedge clk) begin
        clocked <= 1'b1;
        if (!rst_n) begin
            in_balance    <= 0;
            out_balance   <= 0;
            reset_credits <= 0;
            beat_seen     <= 1'b0;
        end else begin
            in_balance  <= in_balance + int'(in_credit) - int'(in_valid);
            out_balance <= out_balance + int'(out_credit) - int'(out_valid);
            // Credits granted before the first beat
            if (!beat_seen) reset_credits <= reset_credits + int'(in_credit);
            if (in_valid) beat_seen <= 1'b1;
        end
    end

    a_in_limit: assert property (@(posedge clk) disable iff (!rst_n)
        in_balance <= IN_CREDITS)
        else begin fail_count++; $error("input credits above FIFO depth"); end

    a_reset_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !beat_seen) |-> (reset_credits + int'(in_credit)) == IN_CREDITS)
        else begin fail_count++; $error("wrong credit count before first beat"); end

    a_out_paid: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_balance > 0)
        else begin fail_count++; $error("out_valid without output credit"); end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid)
        else begin fail_count++; $error("out_last without out_valid"); end

    a_reset_quiet: assert property (@(posedge clk)
        (clocked && !rst_n) |-> !out_valid)
        else begin fail_count++; $error("out_valid high during reset"); end

    a_reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid ##1 !out_valid)
        else begin fail_count++; $error("out_valid high right after reset"); end

endmodule

// File: verification/mm_accel_tb.sv
/*
 * Testbench for mm_accel_top. Five tiles, the last two with large values
 * that saturate. Output credits come with random and long gaps.
 */
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_accel_tb;

    import mm_fixed_pkg::*;
    import mm_stream_pkg::*;

    localparam int NUM_TILES  = 5;
    localparam int NUM_ROWS   = NUM_TILES * `MM_NUM_CORES;
    localparam int WAIT_LIMIT = 20000;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    a_col_t      in_a;
    b_row_t      in_b;
    logic        in_credit;
    logic        out_valid;
    result_row_t out_data;
    logic        out_last;
    logic        out_credit;

    sample_t     a_mat [NUM_TILES][`MM_NUM_CORES][`MM_INNER_DIM];
    sample_t     b_mat [NUM_TILES][`MM_INNER_DIM][`MM_CHUNK_SIZE];
    result_row_t exp_rows [$];
    logic        exp_last [$];
    int          rows_seen;
    int          credits_held;

    mm_accel_top u_mm_accel_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    bind mm_accel_top mm_accel_assertions u_assertions (.*);

    always #50 clk = ~clk;

    task automatic fail_and_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic sample_t small_sample();
        return sample_t'(int'($urandom_range(2047)) - 1024);
    endfunction

    // Full precision sum, floor shift, then clamp to the sample range
    function automatic sample_t model_sample(input int k, input int c, input int j);
        longint sum;
        longint lim;
        sum = 0;
        lim = longint'(1) <<< (`MM_WIDTH - 1);
        for (int t = 0; t < `MM_INNER_DIM; t++) begin
            sum += longint'(a_mat[k][c][t]) * longint'(b_mat[k][t][j]);
        end
        sum = sum >>> `MM_FRAC_WIDTH;
        if (sum >= lim) sum = lim - 1;
        else if (sum < -lim) sum = -lim;
        return sample_t'(sum);
    endfunction

    // Tile 3 spans the full range, tile 4 saturates one way per core
    task automatic build_tiles();
        result_row_t row;
        for (int k = 0; k < NUM_TILES; k++) begin
            for (int t = 0; t < `MM_INNER_DIM; t++) begin
                for (int c = 0; c < `MM_NUM_CORES; c++) begin
                    a_mat[k][c][t] = (k == 3) ? sample_t'($urandom) :
                                     (k == 4) ? ((c % 2 == 0) ? 16'sh7fff : 16'sh8000) :
                                     small_sample();
                end
                for (int j = 0; j < `MM_CHUNK_SIZE; j++) begin
                    b_mat[k][t][j] = (k == 3) ? sample_t'($urandom) :
                                     (k == 4) ? 16'sh8000 : small_sample();
                end
            end
            for (int c = 0; c < `MM_NUM_CORES; c++) begin
                for (int j = 0; j < `MM_CHUNK_SIZE; j++) row[j] = model_sample(k, c, j);
                exp_rows.push_back(row);
                exp_last.push_back(c == `MM_NUM_CORES - 1);
            end
        end
    endtask

    // Advances to the next falling edge at which a credit is held
    task automatic next_credit_edge();
        int waited;
        waited = 0;
        @(negedge clk);
        if (in_credit) credits_held++;
        while (credits_held == 0) begin
            in_valid = 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) fail_and_stop("Timed out waiting for an input credit");
            @(negedge clk);
            if (in_credit) credits_held++;
        end
    endtask

    task automatic send_tiles();
        for (int k = 0; k < NUM_TILES; k++) begin
            for (int t = 0; t < `MM_INNER_DIM; t++) begin
                next_credit_edge();
                in_valid = 1'b1;
                for (int c = 0; c < `MM_NUM_CORES; c++) in_a[c] = a_mat[k][c][t];
                for (int j = 0; j < `MM_CHUNK_SIZE; j++) in_b[j] = b_mat[k][t][j];
                credits_held--;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Long stalls let tiles pile up behind a full buffer
    task automatic grant_out_credits();
        int gap;
        for (int n = 0; n < NUM_ROWS; n++) begin
            gap = (n == 0 || n == 5) ? 300 : int'($urandom_range(6));
            repeat (gap) @(negedge clk);
            out_credit = 1'b1;
            @(negedge clk);
            out_credit = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_rows.size() == 0) fail_and_stop("Output row arrived with none expected");
            assert (out_data == exp_rows[0] && out_last == exp_last[0])
            else fail_and_stop($sformatf("[ERROR] %0t: row %0d got %h last %b, expected %h last %b",
                $time, rows_seen, out_data, out_last, exp_rows[0], exp_last[0]));
            void'(exp_rows.pop_front());
            void'(exp_last.pop_front());
            rows_seen++;
        end
    end

    always @(negedge clk) begin
        if (u_mm_accel_top.u_assertions.fail_count != 0) fail_and_stop("A protocol assertion failed");
    end

    initial begin
        int waited;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_a         = '0;
        in_b         = '0;
        out_credit   = 1'b0;
        rows_seen    = 0;
        credits_held = 0;
        waited       = 0;
        void'($urandom(32'h1d72));
        build_tiles();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Collect the reset credits and wait for the pulses to stop
        while (credits_held < `MM_IN_CREDITS || in_credit) begin
            @(negedge clk);
            if (in_credit) credits_held++;
            waited++;
            if (waited > WAIT_LIMIT) fail_and_stop("Timed out waiting for reset input credits");
        end
        fork
            grant_out_credits();
        join_none
        send_tiles();
        waited = 0;
        while (rows_seen < NUM_ROWS) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_and_stop("Timed out waiting for output rows");
        end
        @(negedge clk);
        if (u_mm_accel_top.u_assertions.fail_count == 0 && exp_rows.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_and_stop("Run ended with a failed check");
        end
    end

endmodule
